//--- rtl/serv_lite_macros.svh
`ifndef SERV_LITE_MACROS_SVH
`define SERV_LITE_MACROS_SVH

// Width of one data word and of one instruction.
`define SL_XLEN 32

// The bit counter walks one word, so it needs log2 of the word width.
`define SL_CNT_W 5

// Architectural registers. Only the low bits of each register field are used.
`define SL_NUM_REGS 8

// Width of a register index.
`define SL_REG_AW $clog2(`SL_NUM_REGS)

`endif

//--- rtl/serv_lite_pkg.sv
`default_nettype none

`include "serv_lite_macros.svh"

package serv_lite_pkg;

   // One data word as held in the register file and the shifter.
   typedef logic [`SL_XLEN-1:0] word_t;

   // Operations that the serial ALU can perform.
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA
   } alu_op_e;

   // The mcause codes that this core can raise.
   typedef enum logic [3:0] {
      CAUSE_BREAKPOINT = 4'd3,
      CAUSE_ECALL      = 4'd11
   } trap_cause_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_type_t;

   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_type_t;

   // The same fetched word seen as an R-type or an I-type instruction.
   typedef union packed {
      r_type_t r;
      i_type_t i;
   } instr_u;

endpackage

`default_nettype wire

//--- rtl/serv_lite_decode.sv
`default_nettype none
`timescale 1ns/1ns

`include "serv_lite_macros.svh"

module serv_lite_decode (
   input  wire                          i_clk,
   input  wire                          i_rst,
   input  wire                          i_ibus_ack,
   input  wire [`SL_XLEN-1:0]           i_ibus_rdt,
   input  wire [`SL_CNT_W-1:0]          i_cnt,
   output serv_lite_pkg::alu_op_e       o_alu_op,
   output logic                         o_use_imm,
   output logic                         o_imm_bit,
   output logic [`SL_REG_AW-1:0]        o_rs1_addr,
   output logic [`SL_REG_AW-1:0]        o_rs2_addr,
   output logic [`SL_REG_AW-1:0]        o_rd_addr,
   output logic                         o_two_stage,
   output logic                         o_e_op,
   output logic                         o_ebreak
);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   serv_lite_pkg::instr_u instr;
   logic                  valid;
   logic                  is_op;
   logic                  is_system;

   // The word is held from one ack to the next.
   always_ff @(posedge i_clk) begin
      if (i_ibus_ack) begin
         instr <= serv_lite_pkg::instr_u'(i_ibus_rdt);
      end
      if (i_rst) begin
         valid <= 1'b0;
      end else if (i_ibus_ack) begin
         valid <= 1'b1;
      end
   end

   assign is_op     = (instr.r.opcode == OPC_OP);
   assign is_system = (instr.r.opcode == OPC_SYSTEM);
   assign o_use_imm = (instr.r.opcode == OPC_OP_IMM);

   assign o_rs1_addr = instr.r.rs1[`SL_REG_AW-1:0];
   assign o_rs2_addr = instr.r.rs2[`SL_REG_AW-1:0];
   assign o_rd_addr  = instr.r.rd[`SL_REG_AW-1:0];

   assign o_e_op   = valid & is_system;
   assign o_ebreak = instr.i.imm12[0];

   // Compares and shifts need an init phase before the result is written.
   assign o_two_stage = valid & ~is_system &
                        ((instr.r.funct3 == 3'b001) | (instr.r.funct3 == 3'b010) |
                         (instr.r.funct3 == 3'b011) | (instr.r.funct3 == 3'b101));

   always_comb begin
      case (instr.r.funct3)
         3'b000:  o_alu_op = (is_op && instr.r.funct7[5]) ? serv_lite_pkg::ALU_SUB
                                                          : serv_lite_pkg::ALU_ADD;
         3'b001:  o_alu_op = serv_lite_pkg::ALU_SLL;
         3'b010:  o_alu_op = serv_lite_pkg::ALU_SLT;
         3'b011:  o_alu_op = serv_lite_pkg::ALU_SLTU;
         3'b100:  o_alu_op = serv_lite_pkg::ALU_XOR;
         3'b101:  o_alu_op = instr.r.funct7[5] ? serv_lite_pkg::ALU_SRA
                                               : serv_lite_pkg::ALU_SRL;
         3'b110:  o_alu_op = serv_lite_pkg::ALU_OR;
         default: o_alu_op = serv_lite_pkg::ALU_AND;
      endcase
   end

   // Above bit 11 the immediate repeats its sign bit.
   assign o_imm_bit = (i_cnt > 5'd11) ? instr.i.imm12[11] : instr.i.imm12[i_cnt[3:0]];

endmodule

`default_nettype wire

//--- rtl/serv_lite_state.sv
`default_nettype none
`timescale 1ns/1ns

`include "serv_lite_macros.svh"

module serv_lite_state (
   input  wire                          i_clk,
   input  wire                          i_rst,
   input  wire                          i_ibus_ack,
   input  wire                          i_two_stage,
   input  wire                          i_shift_op,
   input  wire                          i_e_op,
   input  wire                          i_ebreak,
   input  wire                          i_sh_done,
   output logic                         o_ibus_cyc,
   output logic                         o_init,
   output logic                         o_run,
   output logic                         o_cnt_en,
   output logic [`SL_CNT_W-1:0]         o_cnt,
   output logic                         o_shamt_en,
   output logic                         o_trap,
   output serv_lite_pkg::trap_cause_e   o_mcause,
   output logic                         o_retire
);

   localparam logic [1:0] IDLE = 2'd0;
   localparam logic [1:0] INIT = 2'd1;
   localparam logic [1:0] RUN  = 2'd2;
   localparam logic [1:0] TRAP = 2'd3;

   logic [1:0] state;
   logic [3:0] cnt_r;
   logic       cnt_done;
   logic       busy;
   logic       new_instr;
   logic       stage_two_pending;

   assign o_init     = (state == INIT);
   assign o_run      = (state == RUN);
   assign o_cnt_en   = o_init | o_run;
   assign o_ibus_cyc = ~busy;

   // The shift amount sits in the five lowest operand bits.
   assign o_shamt_en = o_init & (o_cnt < 5);

   always_ff @(posedge i_clk) begin
      new_instr <= i_ibus_ack & o_ibus_cyc;
      o_trap    <= (state == TRAP);
      o_retire  <= o_run & cnt_done;

      // The phase register marks bit 30, so the flag is high during bit 31.
      cnt_done <= (o_cnt[`SL_CNT_W-1:2] == '1) & cnt_r[2];

      o_cnt <= o_cnt + {{(`SL_CNT_W-1){1'b0}}, o_cnt_en};
      if (o_cnt_en) begin
         cnt_r <= {cnt_r[2:0], cnt_r[3]};
      end

      if (state == TRAP) begin
         if (i_ebreak) begin
            o_mcause <= serv_lite_pkg::CAUSE_BREAKPOINT;
         end else begin
            o_mcause <= serv_lite_pkg::CAUSE_ECALL;
         end
      end

      // The bus stays quiet from the fetch until the instruction is done.
      if (i_ibus_ack && o_ibus_cyc) begin
         busy <= 1'b1;
      end else if (o_retire || o_trap) begin
         busy <= 1'b0;
      end

      case (state)
         IDLE: begin
            if (stage_two_pending) begin
               if (i_sh_done) begin
                  state             <= RUN;
                  stage_two_pending <= 1'b0;
               end
            end else if (new_instr) begin
               if (i_e_op) begin
                  state <= TRAP;
               end else if (i_two_stage) begin
                  state <= INIT;
               end else begin
                  state <= RUN;
               end
            end
         end
         INIT: begin
            // Compares write right away, shifts first wait for the shifter.
            if (cnt_done) begin
               state             <= i_shift_op ? IDLE : RUN;
               stage_two_pending <= i_shift_op;
            end
         end
         RUN: begin
            if (cnt_done) begin
               state <= IDLE;
            end
         end
         default: state <= IDLE;
      endcase

      if (i_rst) begin
         state             <= IDLE;
         o_cnt             <= '0;
         cnt_r             <= 4'b0001;
         cnt_done          <= 1'b0;
         busy              <= 1'b0;
         new_instr         <= 1'b0;
         stage_two_pending <= 1'b0;
         o_trap            <= 1'b0;
         o_retire          <= 1'b0;
      end
   end

   a_phase_onehot: assert property (@(posedge i_clk) disable iff (i_rst) $onehot(cnt_r));

   a_trap_not_run: assert property (@(posedge i_clk) disable iff (i_rst) !(o_trap && o_run));

endmodule

`default_nettype wire

//--- rtl/serv_lite_alu.sv
`default_nettype none
`timescale 1ns/1ns

`include "serv_lite_macros.svh"

module serv_lite_alu (
   input  wire                      i_clk,
   input  wire                      i_rst,
   input  serv_lite_pkg::alu_op_e   i_alu_op,
   input  wire                      i_init,
   input  wire                      i_run,
   input  wire                      i_cnt_en,
   input  wire                      i_shamt_en,
   input  wire                      i_rs1_bit,
   input  wire                      i_rs2_bit,
   input  wire                      i_use_imm,
   input  wire                      i_imm_bit,
   output logic                     o_sh_done,
   output logic                     o_rd_bit
);

   serv_lite_pkg::word_t sh_data;
   logic [`SL_CNT_W-1:0] shamt;
   logic                 op_b;
   logic                 b_eff;
   logic                 sub_like;
   logic                 is_shift;
   logic                 carry;
   logic                 sum;
   logic                 cout;
   logic                 a_last;
   logic                 b_last;
   logic                 lt_u;
   logic                 lt_s;
   logic                 run_q;
   logic                 first_run;
   logic                 sh_armed;
   logic                 sh_step;

   assign op_b     = i_use_imm ? i_imm_bit : i_rs2_bit;
   assign sub_like = (i_alu_op == serv_lite_pkg::ALU_SUB) |
                     (i_alu_op == serv_lite_pkg::ALU_SLT) |
                     (i_alu_op == serv_lite_pkg::ALU_SLTU);
   assign is_shift = (i_alu_op == serv_lite_pkg::ALU_SLL) |
                     (i_alu_op == serv_lite_pkg::ALU_SRL) |
                     (i_alu_op == serv_lite_pkg::ALU_SRA);

   // Subtraction adds the inverted operand with a carry-in of one.
   assign b_eff = op_b ^ sub_like;
   assign sum   = i_rs1_bit ^ b_eff ^ carry;
   assign cout  = (i_rs1_bit & b_eff) | (carry & (i_rs1_bit ^ b_eff));

   // After init the carry holds a >= b, and the last bits hold the two signs.
   assign lt_u      = ~carry;
   assign lt_s      = (a_last ^ b_last) ? a_last : lt_u;
   assign first_run = i_run & ~run_q;

   assign sh_step   = sh_armed & ~i_init & (shamt != '0);
   assign o_sh_done = sh_armed & ~i_init & (shamt == '0);

   always_ff @(posedge i_clk) begin
      carry <= i_cnt_en ? cout : sub_like;
      run_q <= i_run;
      if (i_init) begin
         a_last  <= i_rs1_bit;
         b_last  <= op_b;
         sh_data <= {i_rs1_bit, sh_data[`SL_XLEN-1:1]};
      end else if (i_run) begin
         sh_data <= {1'b0, sh_data[`SL_XLEN-1:1]};
      end else if (sh_step) begin
         case (i_alu_op)
            serv_lite_pkg::ALU_SLL: sh_data <= {sh_data[`SL_XLEN-2:0], 1'b0};
            serv_lite_pkg::ALU_SRA: sh_data <= {sh_data[`SL_XLEN-1], sh_data[`SL_XLEN-1:1]};
            default:                sh_data <= {1'b0, sh_data[`SL_XLEN-1:1]};
         endcase
      end
      if (i_shamt_en) begin
         shamt <= {op_b, shamt[`SL_CNT_W-1:1]};
      end else if (sh_step) begin
         shamt <= shamt - 1'b1;
      end
      if (i_init && is_shift) begin
         sh_armed <= 1'b1;
      end else if (o_sh_done) begin
         sh_armed <= 1'b0;
      end
      if (i_rst) begin
         carry    <= 1'b0;
         run_q    <= 1'b0;
         sh_armed <= 1'b0;
      end
   end

   always_comb begin
      case (i_alu_op)
         serv_lite_pkg::ALU_AND:  o_rd_bit = i_rs1_bit & op_b;
         serv_lite_pkg::ALU_OR:   o_rd_bit = i_rs1_bit | op_b;
         serv_lite_pkg::ALU_XOR:  o_rd_bit = i_rs1_bit ^ op_b;
         serv_lite_pkg::ALU_SLT:  o_rd_bit = first_run & lt_s;
         serv_lite_pkg::ALU_SLTU: o_rd_bit = first_run & lt_u;
         serv_lite_pkg::ALU_SLL,
         serv_lite_pkg::ALU_SRL,
         serv_lite_pkg::ALU_SRA:  o_rd_bit = sh_data[0];
         default:                 o_rd_bit = sum;
      endcase
   end

   a_sh_done_not_run: assert property (@(posedge i_clk) disable iff (i_rst) !(o_sh_done && i_run));

endmodule

`default_nettype wire

//--- rtl/serv_lite_regfile.sv
`default_nettype none
`timescale 1ns/1ns

`include "serv_lite_macros.svh"

module serv_lite_regfile (
   input  wire                          i_clk,
   input  wire                          i_rst,
   input  wire                          i_cnt_en,
   input  wire                          i_run,
   input  wire [`SL_REG_AW-1:0]         i_rs1_addr,
   input  wire [`SL_REG_AW-1:0]         i_rs2_addr,
   input  wire [`SL_REG_AW-1:0]         i_rd_addr,
   input  wire                          i_rd_bit,
   input  wire                          i_retire,
   output logic                         o_rs1_bit,
   output logic                         o_rs2_bit,
   output logic                         o_wb_valid,
   output logic [`SL_REG_AW-1:0]        o_wb_rd,
   output logic [`SL_XLEN-1:0]          o_wb_data
);

   serv_lite_pkg::word_t regs [`SL_NUM_REGS];

   // Bit zero of each source is the current serial bit.
   assign o_rs1_bit = regs[i_rs1_addr][0];
   assign o_rs2_bit = regs[i_rs2_addr][0];

   // A source rotates and comes back whole after 32 steps. The destination
   // takes the new bit at the top instead, so it also works when rd is a source.
   always_ff @(posedge i_clk) begin
      for (int r = 0; r < `SL_NUM_REGS; r++) begin
         if (r == 0) begin
            regs[r] <= '0;
         end else if (i_run && (i_rd_addr == r)) begin
            regs[r] <= {i_rd_bit, regs[r][`SL_XLEN-1:1]};
         end else if (i_cnt_en && ((i_rs1_addr == r) || (i_rs2_addr == r))) begin
            regs[r] <= {regs[r][0], regs[r][`SL_XLEN-1:1]};
         end
      end
   end

   // The word is complete one cycle after the last run bit.
   always_ff @(posedge i_clk) begin
      if (i_retire) begin
         o_wb_rd   <= i_rd_addr;
         o_wb_data <= regs[i_rd_addr];
      end
      if (i_rst) begin
         o_wb_valid <= 1'b0;
      end else begin
         o_wb_valid <= i_retire;
      end
   end

endmodule

`default_nettype wire

//--- rtl/serv_lite_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "serv_lite_macros.svh"

module serv_lite_top (
   input  wire                          i_clk,
   input  wire                          i_rst,
   output logic                         o_ibus_cyc,
   input  wire                          i_ibus_ack,
   input  wire [`SL_XLEN-1:0]           i_ibus_rdt,
   output logic                         o_wb_valid,
   output logic [`SL_REG_AW-1:0]        o_wb_rd,
   output logic [`SL_XLEN-1:0]          o_wb_data,
   output logic                         o_trap,
   output serv_lite_pkg::trap_cause_e   o_mcause
);

   serv_lite_pkg::alu_op_e      alu_op;
   logic                        use_imm;
   logic                        imm_bit;
   logic [`SL_REG_AW-1:0]       rs1_addr;
   logic [`SL_REG_AW-1:0]       rs2_addr;
   logic [`SL_REG_AW-1:0]       rd_addr;
   logic                        two_stage;
   logic                        shift_op;
   logic                        e_op;
   logic                        ebreak;
   logic [`SL_CNT_W-1:0]        cnt;
   logic                        cnt_en;
   logic                        init;
   logic                        run;
   logic                        shamt_en;
   logic                        retire;
   logic                        sh_done;
   logic                        rs1_bit;
   logic                        rs2_bit;
   logic                        rd_bit;

   assign shift_op = (alu_op == serv_lite_pkg::ALU_SLL) |
                     (alu_op == serv_lite_pkg::ALU_SRL) |
                     (alu_op == serv_lite_pkg::ALU_SRA);

   serv_lite_decode u_decode (
      .i_clk(i_clk), .i_rst(i_rst), .i_ibus_ack(i_ibus_ack), .i_ibus_rdt(i_ibus_rdt),
      .i_cnt(cnt), .o_alu_op(alu_op), .o_use_imm(use_imm), .o_imm_bit(imm_bit),
      .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_addr(rd_addr),
      .o_two_stage(two_stage), .o_e_op(e_op), .o_ebreak(ebreak));

   serv_lite_state u_state (
      .i_clk(i_clk), .i_rst(i_rst), .i_ibus_ack(i_ibus_ack), .i_two_stage(two_stage),
      .i_shift_op(shift_op), .i_e_op(e_op), .i_ebreak(ebreak), .i_sh_done(sh_done),
      .o_ibus_cyc(o_ibus_cyc), .o_init(init), .o_run(run), .o_cnt_en(cnt_en),
      .o_cnt(cnt), .o_shamt_en(shamt_en), .o_trap(o_trap), .o_mcause(o_mcause),
      .o_retire(retire));

   serv_lite_alu u_alu (
      .i_clk(i_clk), .i_rst(i_rst), .i_alu_op(alu_op), .i_init(init), .i_run(run),
      .i_cnt_en(cnt_en), .i_shamt_en(shamt_en), .i_rs1_bit(rs1_bit), .i_rs2_bit(rs2_bit),
      .i_use_imm(use_imm), .i_imm_bit(imm_bit), .o_sh_done(sh_done), .o_rd_bit(rd_bit));

   serv_lite_regfile u_regfile (
      .i_clk(i_clk), .i_rst(i_rst), .i_cnt_en(cnt_en), .i_run(run),
      .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr), .i_rd_addr(rd_addr),
      .i_rd_bit(rd_bit), .i_retire(retire), .o_rs1_bit(rs1_bit), .o_rs2_bit(rs2_bit),
      .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data));

endmodule

`default_nettype wire

//--- test/serv_lite_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "serv_lite_macros.svh"

module serv_lite_tb;

   localparam int FETCH_TIMEOUT  = 50;
   localparam int RESULT_TIMEOUT = 200;

   logic                        i_clk;
   logic                        i_rst;
   logic                        i_ibus_ack;
   logic [`SL_XLEN-1:0]         i_ibus_rdt;
   logic                        o_ibus_cyc;
   logic                        o_wb_valid;
   logic [`SL_REG_AW-1:0]       o_wb_rd;
   logic [`SL_XLEN-1:0]         o_wb_data;
   logic                        o_trap;
   serv_lite_pkg::trap_cause_e  o_mcause;

   serv_lite_pkg::word_t model [8];
   integer seed = 32'h4efc;
   int     err_count = 0;
   int     check_count = 0;
   int     test_count = 0;

   serv_lite_top u_dut (
      .i_clk(i_clk), .i_rst(i_rst), .o_ibus_cyc(o_ibus_cyc), .i_ibus_ack(i_ibus_ack),
      .i_ibus_rdt(i_ibus_rdt), .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd),
      .o_wb_data(o_wb_data), .o_trap(o_trap), .o_mcause(o_mcause));

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   task automatic abort_run(input string msg);
      $display("ERROR: %s (time %0t)", msg, $time);
      $display("STATUS: FAIL");
      $finish;
   endtask

   task automatic check_wb(input logic [`SL_REG_AW-1:0] exp_rd,
                           input serv_lite_pkg::word_t exp_data);
      check_count++;
      if (o_wb_rd !== exp_rd || o_wb_data !== exp_data) begin
         err_count++;
         $display("Mismatch at %0t: commit x%0d = %h, expected x%0d = %h",
                  $time, o_wb_rd, o_wb_data, exp_rd, exp_data);
      end
   endtask

   task automatic check_trap(input serv_lite_pkg::trap_cause_e exp_cause);
      check_count++;
      if (o_mcause !== exp_cause) begin
         err_count++;
         $display("Mismatch at %0t: mcause %0d, expected %0d", $time, o_mcause, exp_cause);
      end
   endtask

   // funct7 bit 5 and funct3 of each operation, as the ISA encodes them.
   function automatic logic [3:0] funct_bits(input serv_lite_pkg::alu_op_e op);
      case (op)
         serv_lite_pkg::ALU_SUB:  return 4'b1000;
         serv_lite_pkg::ALU_SLL:  return 4'b0001;
         serv_lite_pkg::ALU_SLT:  return 4'b0010;
         serv_lite_pkg::ALU_SLTU: return 4'b0011;
         serv_lite_pkg::ALU_XOR:  return 4'b0100;
         serv_lite_pkg::ALU_SRL:  return 4'b0101;
         serv_lite_pkg::ALU_SRA:  return 4'b1101;
         serv_lite_pkg::ALU_OR:   return 4'b0110;
         serv_lite_pkg::ALU_AND:  return 4'b0111;
         default:                 return 4'b0000;
      endcase
   endfunction

   function automatic serv_lite_pkg::instr_u encode_r(input serv_lite_pkg::alu_op_e op,
         input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
      serv_lite_pkg::instr_u w;
      logic [3:0]            f;
      f = funct_bits(op);
      w.r.funct7 = {1'b0, f[3], 5'b0};
      w.r.rs2    = rs2;
      w.r.rs1    = rs1;
      w.r.funct3 = f[2:0];
      w.r.rd     = rd;
      w.r.opcode = 7'b0110011;
      return w;
   endfunction

   // Arithmetic right shifts by immediate carry funct7 bit 5 in imm12 bit 10.
   function automatic serv_lite_pkg::instr_u encode_i(input serv_lite_pkg::alu_op_e op,
         input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
      serv_lite_pkg::instr_u w;
      logic [3:0]            f;
      f = funct_bits(op);
      w.i.imm12  = imm | {1'b0, f[3], 10'b0};
      w.i.rs1    = rs1;
      w.i.funct3 = f[2:0];
      w.i.rd     = rd;
      w.i.opcode = 7'b0010011;
      return w;
   endfunction

   function automatic serv_lite_pkg::word_t expect_op(input serv_lite_pkg::alu_op_e op,
         input serv_lite_pkg::word_t a, input serv_lite_pkg::word_t b);
      case (op)
         serv_lite_pkg::ALU_SUB:  return a - b;
         serv_lite_pkg::ALU_AND:  return a & b;
         serv_lite_pkg::ALU_OR:   return a | b;
         serv_lite_pkg::ALU_XOR:  return a ^ b;
         serv_lite_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         serv_lite_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
         serv_lite_pkg::ALU_SLL:  return a << b[4:0];
         serv_lite_pkg::ALU_SRL:  return a >> b[4:0];
         serv_lite_pkg::ALU_SRA:  return serv_lite_pkg::word_t'($signed(a) >>> b[4:0]);
         default:                 return a + b;
      endcase
   endfunction

   // Answers one fetch after a random delay of 0 to 5 cycles.
   task automatic fetch(input serv_lite_pkg::instr_u w);
      int waited;
      int delay;
      delay  = {$random(seed)} % 6;
      waited = 0;
      while (!o_ibus_cyc && waited < FETCH_TIMEOUT) begin
         @(posedge i_clk);
         waited++;
      end
      if (!o_ibus_cyc) begin
         abort_run("the core never requested an instruction");
      end else begin
         repeat (delay) @(posedge i_clk);
         i_ibus_ack <= 1'b1;
         i_ibus_rdt <= w;
         @(posedge i_clk);
         i_ibus_ack <= 1'b0;
      end
   endtask

   task automatic run_alu(input serv_lite_pkg::instr_u w, input serv_lite_pkg::word_t exp);
      logic [`SL_REG_AW-1:0] rd;
      int                    waited;
      rd = w.r.rd[`SL_REG_AW-1:0];
      fetch(w);
      waited = 0;
      do begin
         @(posedge i_clk);
         waited++;
         if (o_trap) begin
            err_count++;
            $display("ERROR: an ALU instruction raised a trap (time %0t)", $time);
         end
      end while (!o_wb_valid && waited < RESULT_TIMEOUT);
      if (!o_wb_valid) begin
         abort_run("no commit arrived for an ALU instruction");
      end else begin
         check_wb(rd, (rd == 0) ? '0 : exp);
         if (rd != 0) begin
            model[rd] = exp;
         end
      end
   endtask

   task automatic do_rr(input serv_lite_pkg::alu_op_e op, input int rd, input int rs1,
                        input int rs2);
      run_alu(encode_r(op, 5'(rd), 5'(rs1), 5'(rs2)), expect_op(op, model[rs1], model[rs2]));
   endtask

   task automatic do_imm(input serv_lite_pkg::alu_op_e op, input int rd, input int rs1,
                         input logic [11:0] imm);
      serv_lite_pkg::instr_u w;
      w = encode_i(op, 5'(rd), 5'(rs1), imm);
      run_alu(w, expect_op(op, model[rs1], {{20{w.i.imm12[11]}}, w.i.imm12}));
   endtask

   task automatic run_trap(input logic [11:0] imm, input serv_lite_pkg::trap_cause_e exp);
      serv_lite_pkg::instr_u w;
      int                    waited;
      w.i.imm12  = imm;
      w.i.rs1    = 5'd0;
      w.i.funct3 = 3'd0;
      w.i.rd     = 5'd0;
      w.i.opcode = 7'b1110011;
      fetch(w);
      waited = 0;
      do begin
         @(posedge i_clk);
         waited++;
      end while (!o_trap && !o_wb_valid && waited < RESULT_TIMEOUT);
      if (!o_trap) begin
         abort_run("ecall or ebreak did not raise a trap");
      end else begin
         check_trap(exp);
         // A trap retires nothing, so the commit port must stay quiet.
         repeat (40) begin
            @(posedge i_clk);
            if (o_wb_valid) begin
               err_count++;
               $display("ERROR: a commit followed a trap (time %0t)", $time);
            end
         end
      end
   endtask

   task automatic report(input string name, input int errs_before);
      test_count++;
      $display("%s finished with %0d errors", name, err_count - errs_before);
   endtask

   task automatic test_reset();
      int errs;
      errs = err_count;
      repeat (3) begin
         @(posedge i_clk);
         check_count++;
         if (!o_ibus_cyc || o_wb_valid || o_trap) begin
            err_count++;
            $display("ERROR: bad outputs after reset (time %0t)", $time);
         end
      end
      report("test_reset", errs);
   endtask

   task automatic test_addi();
      int errs;
      errs = err_count;
      for (int r = 1; r < 8; r++) begin
         do_imm(serv_lite_pkg::ALU_ADD, r, 0, 12'($random(seed)));
      end
      report("test_addi", errs);
   endtask

   task automatic test_alu_rr();
      serv_lite_pkg::alu_op_e ops [5];
      int                     errs;
      ops  = '{serv_lite_pkg::ALU_ADD, serv_lite_pkg::ALU_SUB, serv_lite_pkg::ALU_AND,
               serv_lite_pkg::ALU_OR, serv_lite_pkg::ALU_XOR};
      errs = err_count;
      for (int i = 0; i < 25; i++) begin
         do_rr(ops[{$random(seed)} % 5], {$random(seed)} % 7 + 1, {$random(seed)} % 8,
               {$random(seed)} % 8);
      end
      report("test_alu_rr", errs);
   endtask

   task automatic test_compare();
      int errs;
      errs = err_count;
      // x6 negative and x7 positive give a pair whose signs differ.
      do_imm(serv_lite_pkg::ALU_ADD, 6, 0, {1'b1, 11'($random(seed))});
      do_imm(serv_lite_pkg::ALU_ADD, 7, 0, {1'b0, 11'($random(seed))});
      do_rr(serv_lite_pkg::ALU_SLT, 1, 6, 7);
      do_rr(serv_lite_pkg::ALU_SLTU, 2, 6, 7);
      do_rr(serv_lite_pkg::ALU_SLT, 1, 7, 6);
      do_rr(serv_lite_pkg::ALU_SLTU, 2, 7, 6);
      do_rr(serv_lite_pkg::ALU_SLT, 3, 5, 5);
      do_rr(serv_lite_pkg::ALU_SLTU, 3, 4, 4);
      for (int i = 0; i < 10; i++) begin
         do_rr((i % 2) ? serv_lite_pkg::ALU_SLTU : serv_lite_pkg::ALU_SLT, 1,
               {$random(seed)} % 8, {$random(seed)} % 8);
         do_imm((i % 2) ? serv_lite_pkg::ALU_SLT : serv_lite_pkg::ALU_SLTU, 2,
                {$random(seed)} % 8, 12'($random(seed)));
      end
      report("test_compare", errs);
   endtask

   task automatic test_shift();
      serv_lite_pkg::alu_op_e ops [3];
      logic [4:0]             sh;
      int                     errs;
      ops  = '{serv_lite_pkg::ALU_SLL, serv_lite_pkg::ALU_SRL, serv_lite_pkg::ALU_SRA};
      errs = err_count;
      for (int r = 1; r < 7; r++) begin
         do_imm(serv_lite_pkg::ALU_XOR, r, 6 - r + 1, 12'($random(seed)));
      end
      // The upper bits of x7 are random, so only its low five bits may count.
      for (int i = 0; i < 12; i++) begin
         do_imm(serv_lite_pkg::ALU_ADD, 7, 0, 12'($random(seed)));
         do_rr(ops[i % 3], {$random(seed)} % 6 + 1, {$random(seed)} % 6 + 1, 7);
      end
      for (int i = 0; i < 12; i++) begin
         sh = (i == 0) ? 5'd0 : (i == 1) ? 5'd31 : 5'($random(seed));
         do_imm(ops[i % 3], {$random(seed)} % 6 + 1, {$random(seed)} % 6 + 1, {7'b0, sh});
      end
      report("test_shift", errs);
   endtask

   task automatic test_trap();
      int errs;
      errs = err_count;
      run_trap(12'd0, serv_lite_pkg::CAUSE_ECALL);
      run_trap(12'd1, serv_lite_pkg::CAUSE_BREAKPOINT);
      report("test_trap", errs);
   endtask

   task automatic test_x0();
      int errs;
      errs = err_count;
      do_rr(serv_lite_pkg::ALU_ADD, 0, 1, 2);
      do_imm(serv_lite_pkg::ALU_ADD, 0, 3, 12'h7ff);
      do_rr(serv_lite_pkg::ALU_OR, 4, 0, 0);
      do_rr(serv_lite_pkg::ALU_ADD, 5, 0, 3);
      do_imm(serv_lite_pkg::ALU_XOR, 6, 0, 12'h000);
      report("test_x0", errs);
   endtask

   initial begin
      for (int r = 0; r < 8; r++) begin
         model[r] = '0;
      end
      i_rst      <= 1'b1;
      i_ibus_ack <= 1'b0;
      i_ibus_rdt <= '0;
      repeat (4) @(posedge i_clk);
      i_rst <= 1'b0;
      test_reset();
      test_addi();
      test_alu_rr();
      test_compare();
      test_shift();
      test_trap();
      test_x0();
      $display("Done: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- serv_lite.f
+incdir+rtl
rtl/serv_lite_pkg.sv
rtl/serv_lite_decode.sv
rtl/serv_lite_state.sv
rtl/serv_lite_alu.sv
rtl/serv_lite_regfile.sv
rtl/serv_lite_top.sv
test/serv_lite_tb.sv
